// File: rtl/quizPkg.sv
package quizPkg;

    // game phases, codes shared with the board's older decoder
    typedef enum logic [3:0] {
        IDLE     = 4'b0001,
        READY    = 4'b0010,
        QUESTION = 4'b0011,
        INPUT    = 4'b0100,
        RESULT   = 4'b0101
    } gameState_t;

    // everything the main display needs, 12 bits
    typedef struct packed {
        gameState_t state;
        logic [3:0] question;  // digit 0..9
        logic [3:0] tally;     // key rises, 0..9
    } dispReq_t;

    // segment codes, active low, bit 6 = g .. bit 0 = a
    localparam logic [6:0] SEG_READY = 7'b1111011;
    localparam logic [6:0] SEG_BAR   = 7'b0111111;  // middle dash only
    localparam logic [6:0] SEG_BLANK = 7'b1111111;
    localparam logic [6:0] SEG_DIGIT [0:9] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1011000, 7'b0000000, 7'b0010000
    };

    // phase lengths in clock cycles
    localparam int READY_CYCLES    = 4;
    localparam int QUESTION_CYCLES = 6;
    localparam int INPUT_CYCLES    = 40;
    localparam int RESULT_CYCLES   = 3;
    localparam int TIMER_WIDTH     = 6;  // holds INPUT_CYCLES

    // 8-bit fibonacci lfsr, taps 8 6 5 4, new bit in at bit 0
    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam logic [7:0] LFSR_TAPS = 8'b1011_1000;

endpackage

// File: rtl/gameControl.sv
`timescale 1ns/1ps

module gameControl import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       phaseDone,
    output gameState_t state,
    output logic       phaseLoad
);

    gameState_t nextState;  // combinational successor
    logic       changing;   // state moves at the coming edge

    always_comb begin
        nextState = state;  // hold by default
        case (state)
            IDLE: begin
                if (start)
                    nextState = READY;  // only place start is looked at
            end
            READY: begin
                if (phaseDone)
                    nextState = QUESTION;
            end
            QUESTION: begin
                if (phaseDone)
                    nextState = INPUT;
            end
            INPUT: begin
                if (phaseDone)
                    nextState = RESULT;
            end
            RESULT: begin
                if (phaseDone)
                    nextState = IDLE;  // round over
            end
            default: begin
                nextState = IDLE;  // recover from a bad code
            end
        endcase
    end

    // idle has no length, so leaving for idle needs no timer load
    assign changing = (nextState != state) && (nextState != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            phaseLoad <= 1'b0;
        end else begin
            state     <= nextState;
            phaseLoad <= changing;  // high on first cycle of new phase
        end
    end

endmodule

// File: rtl/phaseTimer.sv
`timescale 1ns/1ps

module phaseTimer import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  gameState_t state,
    input  logic       phaseLoad,
    output logic       phaseDone
);

    logic [TIMER_WIDTH-1:0] count;   // cycles left after the current one
    logic [TIMER_WIDTH-1:0] remain;  // load value for this phase

    // load cycle is already part of the phase, hence the minus one
    always_comb begin
        case (state)
            READY:    remain = TIMER_WIDTH'(READY_CYCLES - 1);
            QUESTION: remain = TIMER_WIDTH'(QUESTION_CYCLES - 1);
            INPUT:    remain = TIMER_WIDTH'(INPUT_CYCLES - 1);
            RESULT:   remain = TIMER_WIDTH'(RESULT_CYCLES - 1);
            default:  remain = '0;  // idle is untimed
        endcase
    end

    assign phaseDone = !phaseLoad && (count == TIMER_WIDTH'(1));  // last cycle

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (phaseLoad)
            count <= remain;
        else if (count != '0)
            count <= count - TIMER_WIDTH'(1);  // parks at zero in idle
    end

endmodule

// File: rtl/questionGen.sv
`timescale 1ns/1ps

module questionGen import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  gameState_t state,
    output logic [3:0] question
);

    logic [7:0] lfsr;       // free running, one step per cycle
    logic [3:0] lfsrMod;    // lfsr mod 10
    logic [3:0] heldDigit;  // digit kept for the rest of the round
    gameState_t prevState;  // last cycle's phase
    logic       entering;   // first cycle of QUESTION

    assign lfsrMod  = 4'(lfsr % 8'd10);
    assign entering = (state == QUESTION) && (prevState != QUESTION);

    // bypass on the entry cycle so the digit is there right away
    assign question = entering ? lfsrMod : heldDigit;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr      <= LFSR_SEED;
            heldDigit <= 4'd0;
            prevState <= IDLE;
        end else begin
            lfsr      <= {lfsr[6:0], ^(lfsr & LFSR_TAPS)};  // shift left, feedback at bit 0
            prevState <= state;
            if (entering)
                heldDigit <= lfsrMod;  // frozen until next QUESTION
        end
    end

endmodule

// File: rtl/keyTally.sv
`timescale 1ns/1ps

module keyTally import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  gameState_t state,
    input  logic       key,
    output logic [3:0] tally
);

    logic keyQ;      // key one cycle ago
    logic keyRise;   // 0 -> 1 this cycle
    logic atLimit;   // tally already 9

    assign keyRise = key && !keyQ;
    assign atLimit = (tally == 4'd9);

    always_ff @(posedge clk) begin
        if (reset) begin
            keyQ <= 1'b0;
        end else begin
            keyQ <= key;  // key is already clean and synchronous
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tally <= 4'd0;
        end else begin
            case (state)
                QUESTION: begin
                    tally <= 4'd0;  // zeroed so INPUT starts from nothing
                end
                INPUT: begin
                    if (keyRise && !atLimit)
                        tally <= tally + 4'd1;  // saturates at 9
                end
                default: begin
                    tally <= tally;  // frozen for RESULT and idle
                end
            endcase
        end
    end

endmodule

// File: rtl/scoreKeeper.sv
`timescale 1ns/1ps

module scoreKeeper import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  gameState_t state,
    input  logic [3:0] question,
    input  logic [3:0] tally,
    output logic [3:0] score
);

    logic [3:0] scoreReg;   // stored score
    logic [3:0] scoreNext;  // score if this round is a hit
    gameState_t prevState;
    logic       entering;   // first cycle of RESULT
    logic       hit;        // player matched the digit

    assign entering  = (state == RESULT) && (prevState != RESULT);
    assign hit       = (tally == question);
    assign scoreNext = (scoreReg == 4'd9) ? 4'd0 : scoreReg + 4'd1;  // mod 10

    // new score shows on the very first RESULT cycle
    assign score = (entering && hit) ? scoreNext : scoreReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            scoreReg  <= 4'd0;
            prevState <= IDLE;
        end else begin
            prevState <= state;
            scoreReg  <= score;  // once per round, entry cycle only
        end
    end

endmodule

// File: rtl/seg7Decode.sv
`timescale 1ns/1ps

module seg7Decode import quizPkg::*; (
    input  dispReq_t   disp,
    input  logic [3:0] score,
    output logic [6:0] hexMain,
    output logic [6:0] hexScore
);

    // plain decimal digit, blank for 10..15
    function automatic logic [6:0] digitSeg(input logic [3:0] digit);
        logic [6:0] code;
        if (digit > 4'd9)
            code = SEG_BLANK;
        else
            code = SEG_DIGIT[digit];
        return code;
    endfunction

    // coarse tally level shown while keys are tapped
    function automatic logic [6:0] levelSeg(input logic [3:0] count);
        logic [6:0] code;
        if (count <= 4'd4)
            code = SEG_BAR;       // 0..4, dash
        else if (count <= 4'd8)
            code = SEG_DIGIT[1];  // 5..8
        else
            code = SEG_DIGIT[2];  // 9, saturated
        return code;
    endfunction

    always_comb begin
        case (disp.state)
            READY: begin
                hexMain = SEG_READY;
            end
            QUESTION: begin
                hexMain = digitSeg(disp.question);
            end
            INPUT: begin
                hexMain = levelSeg(disp.tally);
            end
            default: begin
                hexMain = SEG_BLANK;  // idle, result, bad codes
            end
        endcase
    end

    assign hexScore = digitSeg(score);  // always lit

endmodule

// File: rtl/quizTop.sv
`timescale 1ns/1ps

module quizTop import quizPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       key,
    output logic [6:0] hexMain,
    output logic [6:0] hexScore,
    output gameState_t state
);

    logic       phaseLoad;  // controller -> timer
    logic       phaseDone;  // timer -> controller
    logic [3:0] question;
    logic [3:0] tally;
    logic [3:0] score;
    dispReq_t   disp;       // bundle for the main display

    gameControl uControl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .phaseDone (phaseDone),
        .state     (state),
        .phaseLoad (phaseLoad)
    );

    phaseTimer uTimer (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .phaseLoad (phaseLoad),
        .phaseDone (phaseDone)
    );

    questionGen uQuestion (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .question (question)
    );

    keyTally uTally (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .key   (key),
        .tally (tally)
    );

    scoreKeeper uScore (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .question (question),
        .tally    (tally),
        .score    (score)
    );

    assign disp = '{state: state, question: question, tally: tally};  // no register, same cycle

    seg7Decode uDecode (
        .disp     (disp),
        .score    (score),
        .hexMain  (hexMain),
        .hexScore (hexScore)
    );

endmodule

// File: verification/quizTb_asserts.sv
`timescale 1ns/1ps

module quizTb_asserts import quizPkg::*; (
    input logic       clk,
    input logic       reset,
    input gameState_t state,
    input logic       phaseLoad
);

    // timer restart lasts one cycle
    aLoadPulse: assert property (@(posedge clk) disable iff (reset)
        phaseLoad |=> !phaseLoad)
        else $error("phaseLoad high for more than one cycle");

    aLegalState: assert property (@(posedge clk) disable iff (reset)
        state inside {IDLE, READY, QUESTION, INPUT, RESULT})
        else $error("state holds an illegal code");

    // round always ends in idle
    aResultToIdle: assert property (@(posedge clk) disable iff (reset)
        (state == RESULT) |=> (state inside {RESULT, IDLE}))
        else $error("RESULT left for a state other than IDLE");

endmodule

bind gameControl quizTb_asserts uAsserts (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .phaseLoad (phaseLoad)
);

// File: verification/quizTb.sv
`timescale 1ns/1ps

module quizTb import quizPkg::*; ();

    localparam logic [15:0] RAND_SEED = 16'd39093;
    localparam int ROUNDS        = 20;
    localparam int ROUND_TIMEOUT = 100;  // cycles, a full round takes 53

    logic        clk, reset, start, key;
    logic [6:0]  hexMain, hexScore;
    gameState_t  state;
    logic [15:0] randState;  // stimulus lfsr
    int          stateErrors, segErrors, otherErrors;

    // reference model, values for the cycle being driven
    gameState_t mState;
    int         mLeft;   // cycles left in a timed phase, this one included
    logic [7:0] mLfsr;   // own copy of the design lfsr
    logic       mKeyQ;   // key of the previous cycle
    logic [3:0] mTally, mQuestion, mScore;

    quizTop dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .key      (key),
        .hexMain  (hexMain),
        .hexScore (hexScore),
        .state    (state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic logic [15:0] randStep(input logic [15:0] v);
        return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};  // taps 16 14 13 11
    endfunction

    task automatic drawBits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            randState = randStep(randState);  // one step per bit
            bits = {bits[6:0], randState[0]};
        end
    endtask

    // expected main display from the phase rules
    function automatic logic [6:0] mainGlyph(input gameState_t s, input logic [3:0] q,
                                             input logic [3:0] t);
        logic [6:0] glyph;
        case (s)
            READY:    glyph = SEG_READY;
            QUESTION: glyph = SEG_DIGIT[q];
            INPUT:    glyph = (t <= 4'd4) ? SEG_BAR : (t <= 4'd8) ? SEG_DIGIT[1] : SEG_DIGIT[2];
            default:  glyph = SEG_BLANK;  // idle and result
        endcase
        return glyph;
    endfunction

    task automatic checkState(input string name, input gameState_t exp, input gameState_t act);
        if (act !== exp) begin
            stateErrors++;
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkSeg(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp) begin
            segErrors++;
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // advance the model across one rising edge
    task automatic stepModel(input logic startVal, input logic keyVal);
        if (mState == QUESTION)
            mTally = 4'd0;
        else if (mState == INPUT && keyVal && !mKeyQ && mTally != 4'd9)
            mTally = mTally + 4'd1;  // rise counted, stops at 9
        mKeyQ = keyVal;
        mLfsr = {mLfsr[6:0], ^(mLfsr & LFSR_TAPS)};
        mLeft = mLeft - 1;
        if (mState == IDLE && startVal) begin
            mState = READY;
            mLeft  = READY_CYCLES;
        end else if (mState != IDLE && mLeft == 0) begin
            case (mState)
                READY: begin
                    mState    = QUESTION;
                    mLeft     = QUESTION_CYCLES;
                    mQuestion = 4'(mLfsr % 8'd10);  // lfsr of the first QUESTION cycle
                end
                QUESTION: begin
                    mState = INPUT;
                    mLeft  = INPUT_CYCLES;
                end
                INPUT: begin
                    mState = RESULT;
                    mLeft  = RESULT_CYCLES;
                    if (mTally == mQuestion)
                        mScore = (mScore + 4'd1) % 4'd10;  // wraps
                end
                default: begin
                    mState = IDLE;
                end
            endcase
        end
    endtask

    // called right after a rising edge, returns after the next one
    task automatic runCycle(input logic startVal, input logic keyVal, output gameState_t seen);
        start <= startVal;
        key   <= keyVal;
        @(negedge clk);  // outputs settled
        seen = state;
        checkState("state", mState, state);
        checkSeg("hexMain", mainGlyph(mState, mQuestion, mTally), hexMain);
        checkSeg("hexScore", SEG_DIGIT[mScore], hexScore);
        stepModel(startVal, keyVal);
        @(posedge clk);
    endtask

    task automatic pickInputs(input int mode, output logic startVal, output logic keyVal);
        logic [7:0] bits;
        drawBits(2, bits);
        startVal = bits[1] && (mState != IDLE);  // stray starts only while busy
        keyVal   = bits[0];  // random taps, outside INPUT too
        if (mState == INPUT && mode < 2)
            keyVal = (mTally < mQuestion) && !mKeyQ;  // tap exactly the digit
        else if (mState == INPUT && mode == 2)
            keyVal = !mKeyQ;  // rise every other cycle, saturates
    endtask

    task automatic playRound(input int mode, output logic hung);
        logic [7:0] bits;
        logic       startVal, keyVal;
        gameState_t seen;
        int         cycles;
        drawBits(3, bits);
        for (int i = 0; i < int'(bits[2:0]); i++) begin  // random idle gap
            pickInputs(mode, startVal, keyVal);
            runCycle(1'b0, keyVal, seen);
        end
        pickInputs(mode, startVal, keyVal);
        runCycle(1'b1, keyVal, seen);
        cycles = 0;
        do begin
            pickInputs(mode, startVal, keyVal);
            runCycle(startVal, keyVal, seen);
            cycles++;
        end while (seen != IDLE && cycles < ROUND_TIMEOUT);
        hung = (seen != IDLE);
        if (hung)
            $display("round did not return to IDLE within %0d cycles", ROUND_TIMEOUT);
    endtask

    initial begin
        logic       hung;
        logic       startVal, keyVal;
        gameState_t seen;
        hung        = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        key         = 1'b0;
        randState   = RAND_SEED;
        stateErrors = 0;
        segErrors   = 0;
        otherErrors = 0;
        mState      = IDLE;
        mLeft       = 0;
        mLfsr       = LFSR_SEED;
        mKeyQ       = 1'b0;
        mTally      = 4'd0;
        mQuestion   = 4'd0;
        mScore      = 4'd0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (8) begin  // start low, idle taps do nothing
            pickInputs(0, startVal, keyVal);
            runCycle(1'b0, keyVal, seen);
        end
        for (int r = 0; r < ROUNDS && !hung; r++)
            playRound(r % 4, hung);  // 0 and 1 match, 2 heavy, 3 random
        if (hung)
            otherErrors++;
        $display("errors: state %0d, segment %0d, other %0d", stateErrors, segErrors, otherErrors);
        if (stateErrors + segErrors + otherErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: compile.f
rtl/quizPkg.sv
rtl/gameControl.sv
rtl/phaseTimer.sv
rtl/questionGen.sv
rtl/keyTally.sv
rtl/scoreKeeper.sv
rtl/seg7Decode.sv
rtl/quizTop.sv
verification/quizTb_asserts.sv
verification/quizTb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module quizTb -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/VquizTb | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
